// ==== mulDivPkg.sv ====
/*
 shared types for the slow multiply/divide unit
 imported by the decoder, issue control, engine and testbench
*/

package mulDivPkg;

	// datapath width of the execute stage
	localparam int xlen = 64;

	// RISC-V M extension operations
	typedef enum logic [3:0]
	{
		opMul = 4'h0,
		opMulh = 4'h1,
		opMulhsu = 4'h2,
		opMulhu = 4'h3,
		opDiv = 4'h4,
		opDivu = 4'h5,
		opRem = 4'h6,
		opRemu = 4'h7,
		opMulw = 4'h8,
		opDivw = 4'h9,
		opDivuw = 4'ha,
		opRemw = 4'hb,
		opRemuw = 4'hc
	} mulDivOp;

	// engine controls decoded from the opcode
	typedef struct packed
	{
		// divide, else multiply
		logic isDiv;
		// operand signedness
		logic signA;
		logic signB;
		// low 32 bits only, result sign extended from bit 31
		logic isWord;
		// high product or remainder
		logic selHigh;
	} mulDivCtrl;

	// engine result
	// multiply gives hi:lo product, divide gives quotient in lo, remainder in hi
	typedef struct packed
	{
		logic [xlen-1:0] hi;
		logic [xlen-1:0] lo;
	} mulDivPair;

	// issue control states
	typedef enum logic [1:0]
	{
		stIdle = 2'd0,
		// engine running, pipeline held
		stBusy = 2'd1,
		// result cycle
		stDone = 2'd2
	} issueState;

endpackage

// ==== mulDivDecode.sv ====
/*
 opcode decoder for the slow multiply/divide unit
 purely combinational, feeds the issue control and the engine
*/

`timescale 1ns/1ps

module mulDivDecode import mulDivPkg::*;
(
	input mulDivOp op,
	output mulDivCtrl ctrl
);

	always_comb
	begin
		// unused codes fall back to a plain low multiply
		ctrl = '0;
		case (op)
			opMul:
			begin
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
			end
			opMulh:
			begin
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			opMulhsu:
			begin
				// only the first operand is signed
				ctrl.signA = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			opMulhu:
				ctrl.selHigh = 1'b1;
			opDiv:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
			end
			opDivu:
				ctrl.isDiv = 1'b1;
			opRem:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			opRemu:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			opMulw:
			begin
				// low product bits do not depend on signedness
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
				ctrl.isWord = 1'b1;
			end
			opDivw:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
				ctrl.isWord = 1'b1;
			end
			opDivuw:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.isWord = 1'b1;
			end
			opRemw:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.signA = 1'b1;
				ctrl.signB = 1'b1;
				ctrl.isWord = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			opRemuw:
			begin
				ctrl.isDiv = 1'b1;
				ctrl.isWord = 1'b1;
				ctrl.selHigh = 1'b1;
			end
			default:
				ctrl = '0;
		endcase
	end

endmodule

// ==== shiftAddCore.sv ====
/*
 iterative shift-add multiplier and restoring divider, one operand bit per cycle
 runs width+2 cycles after start: load, width iterations, sign fixup
*/

`timescale 1ns/1ps

module shiftAddCore import mulDivPkg::*;
#(
	parameter int width = xlen
)
(
	input logic clock,
	input logic rstN,
	input logic start,
	input mulDivCtrl ctrl,
	input logic [width-1:0] srcA,
	input logic [width-1:0] srcB,
	output logic done,
	output mulDivPair pair
);

	localparam int cntW = $clog2(width + 1);

	// iteration control
	logic running;
	logic [cntW-1:0] cnt;

	// accumulator / remainder, multiplier / quotient, multiplicand / divisor
	logic [width-1:0] hi;
	logic [width-1:0] lo;
	logic [width-1:0] bOp;

	// recorded result signs
	logic negRes;
	logic negRem;

	// operands after word truncation
	logic [width-1:0] aExt;
	logic [width-1:0] bExt;
	logic aNeg;
	logic bNeg;

	// one iteration step
	logic [width:0] addSum;
	logic [width:0] trialRem;
	logic [width:0] trialDiff;

	// fixup values
	logic [2*width-1:0] prodFix;
	logic [width-1:0] quoFix;
	logic [width-1:0] remFix;
	logic divZero;

	always_comb
	begin
		aExt = srcA;
		bExt = srcB;
		// word forms see only bits 31:0, extended by their signedness
		if (ctrl.isWord)
		begin
			aExt = {{(width-32){ctrl.signA & srcA[31]}}, srcA[31:0]};
			bExt = {{(width-32){ctrl.signB & srcB[31]}}, srcB[31:0]};
		end
		aNeg = ctrl.signA & aExt[width-1];
		bNeg = ctrl.signB & bExt[width-1];
	end

	always_comb
	begin
		// multiply: add multiplicand when the low multiplier bit is set
		addSum = {1'b0, hi} + (lo[0] ? {1'b0, bOp} : {(width+1){1'b0}});
		// divide: shift next dividend bit into remainder, trial subtract
		trialRem = {hi, lo[width-1]};
		trialDiff = trialRem - {1'b0, bOp};
	end

	always_comb
	begin
		prodFix = negRes ? -{hi, lo} : {hi, lo};
		divZero = (bOp == '0);
		// zero divisor leaves the dividend magnitude in the remainder already
		quoFix = divZero ? {width{1'b1}} : (negRes ? -lo : lo);
		// remainder follows the dividend sign
		remFix = negRem ? -hi : hi;
	end

	// sequencing
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			running <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				cnt <= cntW'(width);
			end
			else if (running)
			begin
				if (cnt != '0)
					cnt <= cnt - 1'b1;
				else
				begin
					// fixup cycle
					running <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clock)
	begin
		if (start)
		begin
			// load magnitudes
			hi <= '0;
			lo <= aNeg ? -aExt : aExt;
			bOp <= bNeg ? -bExt : bExt;
			negRes <= aNeg ^ bNeg;
			negRem <= aNeg;
		end
		else if (running)
		begin
			if (cnt != '0)
			begin
				if (ctrl.isDiv)
				begin
					// keep difference when non-negative
					if (!trialDiff[width])
					begin
						hi <= trialDiff[width-1:0];
						lo <= {lo[width-2:0], 1'b1};
					end
					else
					begin
						hi <= trialRem[width-1:0];
						lo <= {lo[width-2:0], 1'b0};
					end
				end
				else
				begin
					// carry into accumulator, product bit into multiplier
					hi <= addSum[width:1];
					lo <= {addSum[0], lo[width-1:1]};
				end
			end
			else if (ctrl.isDiv)
			begin
				lo <= quoFix;
				hi <= remFix;
			end
			else
				{hi, lo} <= prodFix;
		end
	end

	assign pair.hi = hi;
	assign pair.lo = lo;

endmodule

// ==== mulDivIssue.sv ====
/*
 issue control for the slow multiply/divide unit
 holds the pipeline with busy, selects and extends the result, pulses resultValid
*/

`timescale 1ns/1ps

module mulDivIssue import mulDivPkg::*;
#(
	parameter int width = xlen
)
(
	input logic clock,
	input logic rstN,
	input logic issue,
	input mulDivCtrl ctrlIn,
	input logic done,
	input mulDivPair pair,
	output logic start,
	output logic busy,
	output logic resultValid,
	output mulDivCtrl ctrlOut,
	output logic [width-1:0] result
);

	issueState state;
	issueState stateNxt;

	// control of the operation in flight
	mulDivCtrl ctrlReg;

	// selected engine word
	logic [width-1:0] selWord;

	// issue taken whenever the engine is free, busy low in idle and done
	assign start = issue && (state != stBusy);

	// engine sees decoded control at start, held control while running
	assign ctrlOut = (state == stBusy) ? ctrlReg : ctrlIn;

	always_comb
	begin
		stateNxt = state;
		case (state)
			stIdle,
			stDone:
				if (issue)
					stateNxt = stBusy;
				else
					stateNxt = stIdle;
			stBusy:
				if (done)
					stateNxt = stDone;
			default:
				stateNxt = stIdle;
		endcase
	end

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= stIdle;
		else
			state <= stateNxt;
	end

	// busy drops together with the valid pulse
	assign busy = (state == stBusy);
	assign resultValid = (state == stDone);

	always_ff @(posedge clock)
	begin
		if (start)
			ctrlReg <= ctrlIn;
	end

	always_comb
	begin
		selWord = ctrlReg.selHigh ? pair.hi : pair.lo;
		// word forms take bit 31 as sign
		if (ctrlReg.isWord)
			selWord = {{(width-32){selWord[31]}}, selWord[31:0]};
	end

	// result holds until the next completion
	always_ff @(posedge clock)
	begin
		if ((state == stBusy) && done)
			result <= selWord;
	end

endmodule

// ==== sloMulDivTop.sv ====
/*
 slow multiply/divide unit for the 64-bit execute stage
 issue with op and operands while busy is low, result comes with resultValid
*/

`timescale 1ns/1ps

module sloMulDivTop import mulDivPkg::*;
#(
	parameter int width = xlen
)
(
	input logic clock,
	input logic rstN,
	input logic issue,
	input mulDivOp op,
	input logic [width-1:0] srcA,
	input logic [width-1:0] srcB,
	output logic busy,
	output logic resultValid,
	output logic [width-1:0] result
);

	// decoded and held controls
	mulDivCtrl ctrlDec;
	mulDivCtrl ctrlEng;

	// engine handshake
	logic start;
	logic done;
	mulDivPair pair;

	mulDivDecode i_decode
	(
		.op(op),
		.ctrl(ctrlDec)
	);

	mulDivIssue #(.width(width)) i_issue
	(
		.clock(clock),
		.rstN(rstN),
		.issue(issue),
		.ctrlIn(ctrlDec),
		.done(done),
		.pair(pair),
		.start(start),
		.busy(busy),
		.resultValid(resultValid),
		.ctrlOut(ctrlEng),
		.result(result)
	);

	// engine takes operands straight from the issue cycle
	shiftAddCore #(.width(width)) i_core
	(
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.ctrl(ctrlEng),
		.srcA(srcA),
		.srcB(srcB),
		.done(done),
		.pair(pair)
	);

endmodule

// ==== tbSloMulDiv.sv ====
/*
 testbench for the slow multiply/divide unit
 replays mulDivPatterns.txt, then seeded random cases checked against RISC-V rules
*/

`timescale 1ns/1ps

module tbSloMulDiv import mulDivPkg::*;
;

	localparam int numPat = 22;
	localparam int numRand = 24;
	// issue to resultValid, same for every operation
	localparam int latency = xlen + 3;
	localparam int timeoutCycles = (numPat + numRand) * 80 + 200;

	logic clock;
	logic rstN;
	logic issue;
	mulDivOp op;
	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic busy;
	logic resultValid;
	logic [xlen-1:0] result;

	// four words per line: opcode, a, b, expected
	logic [63:0] patMem [0:4*numPat-1];

	int errCount;
	int checkCount;
	int cycleCount;
	integer seed;

	sloMulDivTop #(.width(xlen)) i_dut
	(
		.clock(clock),
		.rstN(rstN),
		.issue(issue),
		.op(op),
		.srcA(srcA),
		.srcB(srcB),
		.busy(busy),
		.resultValid(resultValid),
		.result(result)
	);

	// 4 ns period
	always #2 clock = ~clock;

	// run limit
	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles)
		begin
			$display("timeout after %0d cycles, the DUT stopped returning results", cycleCount);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (actual !== expected)
		begin
			errCount++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// RISC-V M reference, straight from the spec rules
	function automatic logic [63:0] expectedResult(input mulDivOp opc, input logic [63:0] a,
		input logic [63:0] b);
		logic [127:0] full;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [31:0] wa;
		logic signed [31:0] wb;
		logic [31:0] w;
		logic [63:0] res;
		sa = a;
		sb = b;
		wa = a[31:0];
		wb = b[31:0];
		w = '0;
		res = '0;
		case (opc)
			opMul: res = a * b;
			opMulh:
			begin
				full = {{64{a[63]}}, a} * {{64{b[63]}}, b};
				res = full[127:64];
			end
			opMulhsu:
			begin
				full = {{64{a[63]}}, a} * {64'd0, b};
				res = full[127:64];
			end
			opMulhu:
			begin
				full = {64'd0, a} * {64'd0, b};
				res = full[127:64];
			end
			opDiv:
				if (b == '0)
					res = '1;
				else if (a == 64'h8000_0000_0000_0000 && b == '1)
					res = a;
				else
					res = sa / sb;
			opRem:
				if (b == '0)
					res = a;
				else if (a == 64'h8000_0000_0000_0000 && b == '1)
					res = '0;
				else
					res = sa % sb;
			opDivu: res = (b == '0) ? '1 : a / b;
			opRemu: res = (b == '0) ? a : a % b;
			opMulw: w = a[31:0] * b[31:0];
			opDivw:
				if (wb == 0)
					w = '1;
				else if (wa == 32'sh8000_0000 && wb == -1)
					w = wa;
				else
					w = wa / wb;
			opRemw:
				if (wb == 0)
					w = wa;
				else if (wa == 32'sh8000_0000 && wb == -1)
					w = '0;
				else
					w = wa % wb;
			opDivuw: w = (b[31:0] == '0) ? '1 : a[31:0] / b[31:0];
			opRemuw: w = (b[31:0] == '0) ? a[31:0] : a[31:0] % b[31:0];
			default: res = '0;
		endcase
		// word forms sign extend bit 31
		if (opc >= opMulw)
			res = {{32{w[31]}}, w};
		return res;
	endfunction

	// idle unit: no busy, no result
	task automatic checkQuiet(input string name, input int n);
		repeat (n)
		begin
			@(posedge clock);
			#0.5;
			checkValue({name, " busy"}, 64'd0, 64'(busy));
			checkValue({name, " valid"}, 64'd0, 64'(resultValid));
		end
	endtask

	// one issue, timed and checked, optional strobe while busy
	task automatic runOp(input string name, input mulDivOp opc, input logic [63:0] a,
		input logic [63:0] b, input logic [63:0] expected, input bit strayIssue);
		int cycles;
		while (busy)
		begin
			@(posedge clock);
			#0.5;
		end
		issue = 1'b1;
		op = opc;
		srcA = a;
		srcB = b;
		@(posedge clock);
		#0.5;
		issue = 1'b0;
		cycles = 1;
		while (!resultValid)
		begin
			checkValue({name, " busy"}, 64'd1, 64'(busy));
			// issue during the run, must be dropped
			issue = strayIssue && (cycles == 20);
			if (issue)
			begin
				op = opDivu;
				srcA = ~a;
				srcB = 64'd3;
			end
			@(posedge clock);
			#0.5;
			cycles++;
		end
		issue = 1'b0;
		checkValue({name, " latency"}, 64'(latency), 64'(cycles));
		checkValue({name, " busy at valid"}, 64'd0, 64'(busy));
		checkValue(name, expected, result);
	endtask

	initial
	begin
		mulDivOp rOp;
		logic [63:0] rA;
		logic [63:0] rB;
		logic [31:0] r;
		int mode;
		bit patOk;
		clock = 1'b0;
		rstN = 1'b0;
		issue = 1'b0;
		op = opMul;
		srcA = '0;
		srcB = '0;
		seed = 32'hb9fa;
		errCount = 0;
		checkCount = 0;
		cycleCount = 0;
		// unloaded entries keep an out of range opcode
		for (int j = 0; j < 4 * numPat; j++)
			patMem[j] = {32'hffff_ffff, 32'(j)};
		$readmemh("mulDivPatterns.txt", patMem);
		patOk = 1'b1;
		for (int i = 0; i < numPat; i++)
			if (patMem[4*i] > 64'd12)
				patOk = 1'b0;
		if (!patOk)
		begin
			errCount++;
			$display("pattern file mulDivPatterns.txt is missing, short or has a bad opcode");
		end

		// reset, outputs low throughout
		repeat (10)
		begin
			@(posedge clock);
			#0.5;
			checkValue("reset busy", 64'd0, 64'(busy));
			checkValue("reset valid", 64'd0, 64'(resultValid));
		end
		rstN = 1'b1;
		checkQuiet("after reset", 5);

		if (patOk)
		begin
			for (int i = 0; i < numPat; i++)
			begin
				runOp($sformatf("pattern %0d", i), mulDivOp'(patMem[4*i][3:0]),
					patMem[4*i+1], patMem[4*i+2], patMem[4*i+3], i == 4);
				// stray issue of pattern 4 gives no second result
				if (i == 4)
					checkQuiet("stray issue", 70);
			end
		end

		for (int k = 0; k < numRand; k++)
		begin
			rOp = mulDivOp'(4'($unsigned($random(seed)) % 13));
			rA = {$random(seed), $random(seed)};
			mode = $unsigned($random(seed)) % 4;
			r = $random(seed);
			case (mode)
				0: rB = {$random(seed), r};
				// small signed divisor
				1: rB = {{48{r[15]}}, r[15:0]};
				2: rB = '0;
				default:
				begin
					// overflow corner, 64-bit or word
					rB = '1;
					rA = r[0] ? 64'h8000_0000_0000_0000 : {r, 32'h8000_0000};
				end
			endcase
			runOp($sformatf("random %0d", k), rOp, rA, rB, expectedResult(rOp, rA, rB), 1'b0);
		end

		$display("checks %0d, errors %0d", checkCount, errCount);
		if (errCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== mulDivPatterns.txt ====
// columns: opcode, operand a, operand b, expected result, all hex
// opcodes: 0 mul 1 mulh 2 mulhsu 3 mulhu 4 div 5 divu 6 rem 7 remu 8 mulw 9 divw a divuw b remw c remuw
0 0000000000000007 0000000000000006 000000000000002a
0 fffffffffffffffd 0000000000000005 fffffffffffffff1
1 ffffffffffffffff ffffffffffffffff 0000000000000000
1 4000000000000000 0000000000000004 0000000000000001
1 c000000000000000 0000000000000004 ffffffffffffffff
3 ffffffffffffffff ffffffffffffffff fffffffffffffffe
2 ffffffffffffffff ffffffffffffffff ffffffffffffffff
2 0000000000000002 8000000000000000 0000000000000001
4 fffffffffffffff9 0000000000000002 fffffffffffffffd
6 fffffffffffffff9 0000000000000002 ffffffffffffffff
5 0000000000000064 0000000000000007 000000000000000e
7 0000000000000064 0000000000000007 0000000000000002
4 0000000000001234 0000000000000000 ffffffffffffffff
6 fffffffffffffff9 0000000000000000 fffffffffffffff9
4 8000000000000000 ffffffffffffffff 8000000000000000
6 8000000000000000 ffffffffffffffff 0000000000000000
8 123456787fffffff 0000000000000002 fffffffffffffffe
9 abcdef00ffffff9c 0000000000000007 fffffffffffffff2
a 0000000080000000 0000000000000002 0000000040000000
b 00000000ffffff9c 0000000000000007 fffffffffffffffe
c 00000000fffffff9 0000000000000000 fffffffffffffff9
9 0000000080000000 00000000ffffffff ffffffff80000000

// ==== sloMulDiv.f ====
mulDivPkg.sv
mulDivDecode.sv
shiftAddCore.sv
mulDivIssue.sv
sloMulDivTop.sv
tbSloMulDiv.sv

// ==== runSim.sh ====
#!/bin/sh
# build the multiply/divide testbench with Verilator, run it, grep the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir simLog.txt
verilator --binary --timing -Wno-fatal --top-module tbSloMulDiv -f sloMulDiv.f -o simSloMulDiv \
	&& ./obj_dir/simSloMulDiv > simLog.txt 2>&1 \
	|| { cat simLog.txt 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat simLog.txt
grep -qF '*** TEST PASSED ***' simLog.txt && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
